/* common/micro_core_pkg.sv */
package micro_core_pkg;

    ////////////////////////////////////////
    // basic widths
    ////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;

    // one request on the four-phase bus
    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        logic     write;
        byte_en_t be;
    } bus_req_t;

    ////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // same word, two views
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_u;

    // exec to load/store command
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
        logic  is_byte;
        logic  zero_ext;
    } mem_op_t;

    // register write as seen on the debug trace
    typedef struct packed {
        word_t     pc;
        reg_addr_t wnum;
        word_t     wdata;
    } trace_t;

    ////////////////////////////////////////
    // opcodes and funct codes
    ////////////////////////////////////////

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_lbu     = 6'h24;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_or   = 6'h25;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter micro_core_pkg::word_t reset_pc = 32'h0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       inst_take,
    output logic                       inst_valid,
    output micro_core_pkg::inst_word_u inst,
    output micro_core_pkg::word_t      inst_pc,
    output logic                       fetch_req,
    output micro_core_pkg::bus_req_t   fetch_cmd,
    input  logic                       fetch_ack,
    input  micro_core_pkg::word_t      rdata
);
    import micro_core_pkg::*;

    // address of the buffered word, or of the word being fetched
    word_t pc;
    logic  buf_free;

    assign buf_free = !inst_valid || inst_take;
    assign inst_pc  = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= reset_pc;
            fetch_req  <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            // sequential only, no branches
            if (inst_take) begin
                pc         <= pc + 32'd4;
                inst_valid <= 1'b0;
            end
            if (fetch_req && fetch_ack) begin
                fetch_req  <= 1'b0;
                inst_valid <= 1'b1;
            end else if (!fetch_req && !fetch_ack && buf_free) begin
                fetch_req <= 1'b1;
            end
        end
    end

    // prefetch buffer
    always_ff @(posedge clk) begin
        if (fetch_req && fetch_ack) begin
            inst <= rdata;
        end
    end

    always_comb begin
        fetch_cmd       = '0;
        fetch_cmd.addr  = pc;
        fetch_cmd.write = 1'b0;
        fetch_cmd.be    = 4'hf;
    end

endmodule

/* design/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mem_start,
    input  micro_core_pkg::mem_op_t  mem_op,
    output logic                     mem_done,
    output micro_core_pkg::word_t    load_data,
    output logic                     data_req,
    output micro_core_pkg::bus_req_t data_cmd,
    input  logic                     data_ack,
    input  micro_core_pkg::word_t    rdata
);
    import micro_core_pkg::*;

    mem_op_t    op_q;
    word_t      rdata_q;
    logic       wait_fall;
    logic [7:0] lane;

    ////////////////////////////////////////
    // four-phase transfer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            data_req  <= 1'b0;
            wait_fall <= 1'b0;
        end else begin
            if (mem_start) begin
                data_req <= 1'b1;
            end else if (data_req && data_ack) begin
                data_req  <= 1'b0;
                wait_fall <= 1'b1;
            end else if (mem_done) begin
                wait_fall <= 1'b0;
            end
        end
    end

    // done in the first cycle with ack low again
    assign mem_done = wait_fall && !data_ack;

    always_ff @(posedge clk) begin
        if (mem_start) begin
            op_q <= mem_op;
        end
        if (data_req && data_ack) begin
            rdata_q <= rdata;
        end
    end

    always_comb begin
        data_cmd.addr  = op_q.addr;
        data_cmd.wdata = op_q.wdata;
        data_cmd.write = op_q.write;
        // single lane for byte loads
        if (op_q.is_byte) begin
            data_cmd.be = byte_en_t'(4'b0001 << op_q.addr[1:0]);
        end else begin
            data_cmd.be = 4'hf;
        end
    end

    ////////////////////////////////////////
    // load alignment, little-endian
    ////////////////////////////////////////

    assign lane = rdata_q[op_q.addr[1:0]*8 +: 8];

    always_comb begin
        if (!op_q.is_byte) begin
            load_data = rdata_q;
        end else if (op_q.zero_ext) begin
            load_data = {24'h0, lane};
        end else begin
            load_data = {{24{lane[7]}}, lane};
        end
    end

endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fetch_req,
    input  micro_core_pkg::bus_req_t fetch_cmd,
    output logic                     fetch_ack,
    input  logic                     data_req,
    input  micro_core_pkg::bus_req_t data_cmd,
    output logic                     data_ack,
    output logic                     mem_req,
    output micro_core_pkg::bus_req_t mem_cmd,
    input  logic                     mem_ack
);

    logic grant_valid;
    logic grant_data;
    // ack has gone high for the current grant
    logic ack_seen;

    always_ff @(posedge clk) begin
        if (reset) begin
            grant_valid <= 1'b0;
            grant_data  <= 1'b0;
            ack_seen    <= 1'b0;
        end else if (!grant_valid) begin
            ack_seen <= 1'b0;
            // data side wins a tie
            if (!mem_ack && (data_req || fetch_req)) begin
                grant_valid <= 1'b1;
                grant_data  <= data_req;
            end
        end else begin
            if (mem_ack) begin
                ack_seen <= 1'b1;
            end else if (ack_seen) begin
                // ack fell, transfer complete
                grant_valid <= 1'b0;
            end
        end
    end

    assign mem_req = grant_valid && (grant_data ? data_req : fetch_req);
    assign mem_cmd = grant_data ? data_cmd : fetch_cmd;

    // ack goes only to the granted side
    assign data_ack  = grant_valid && grant_data && mem_ack;
    assign fetch_ack = grant_valid && !grant_data && mem_ack;

endmodule

/* core/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       inst_valid,
    input  micro_core_pkg::inst_word_u inst,
    input  micro_core_pkg::word_t      inst_pc,
    output logic                       inst_take,
    output micro_core_pkg::reg_addr_t  rs_addr,
    output micro_core_pkg::reg_addr_t  rt_addr,
    input  micro_core_pkg::word_t      rs_data,
    input  micro_core_pkg::word_t      rt_data,
    output logic                       rf_wen,
    output micro_core_pkg::reg_addr_t  rf_waddr,
    output micro_core_pkg::word_t      rf_wdata,
    output logic                       mem_start,
    output micro_core_pkg::mem_op_t    mem_op,
    input  logic                       mem_done,
    input  micro_core_pkg::word_t      load_data,
    output logic                       trace_valid,
    output micro_core_pkg::trace_t     trace
);
    import micro_core_pkg::*;

    word_t     imm_sext;
    word_t     alu_res;
    reg_addr_t dest;
    logic      alu_wen;
    logic      is_load;
    logic      is_store;
    logic      mem_busy;
    logic      alu_wen_q;
    logic      load_q;
    reg_addr_t waddr_q;
    word_t     wdata_q;
    word_t     pc_q;

    assign rs_addr  = inst.i.rs;
    assign rt_addr  = inst.i.rt;
    assign imm_sext = {{16{inst.i.imm[15]}}, inst.i.imm};

    assign inst_take = inst_valid && !mem_busy;

    ////////////////////////////////////////
    // decode and ALU
    ////////////////////////////////////////

    always_comb begin
        alu_res  = '0;
        alu_wen  = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        dest     = inst.i.rt;
        case (inst.r.opcode)
            op_special: begin
                dest = inst.r.rd;
                case (inst.r.funct)
                    fn_addu: begin
                        alu_res = rs_data + rt_data;
                        alu_wen = 1'b1;
                    end
                    fn_subu: begin
                        alu_res = rs_data - rt_data;
                        alu_wen = 1'b1;
                    end
                    fn_or: begin
                        alu_res = rs_data | rt_data;
                        alu_wen = 1'b1;
                    end
                    default: alu_wen = 1'b0;
                endcase
            end
            op_addiu: begin
                alu_res = rs_data + imm_sext;
                alu_wen = 1'b1;
            end
            op_ori: begin
                alu_res = rs_data | {16'h0, inst.i.imm};
                alu_wen = 1'b1;
            end
            op_lui: begin
                alu_res = {inst.i.imm, 16'h0};
                alu_wen = 1'b1;
            end
            op_lw, op_lb, op_lbu: is_load = 1'b1;
            op_sw: is_store = 1'b1;
            // anything else retires silently
            default: alu_wen = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_wen_q <= 1'b0;
            mem_start <= 1'b0;
            mem_busy  <= 1'b0;
            load_q    <= 1'b0;
        end else begin
            alu_wen_q <= inst_take && alu_wen;
            mem_start <= inst_take && (is_load || is_store);
            if (inst_take && (is_load || is_store)) begin
                mem_busy <= 1'b1;
                load_q   <= is_load;
            end else if (mem_done) begin
                mem_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_take) begin
            waddr_q         <= dest;
            wdata_q         <= alu_res;
            pc_q            <= inst_pc;
            mem_op.addr     <= rs_data + imm_sext;
            mem_op.wdata    <= rt_data;
            mem_op.write    <= is_store;
            mem_op.is_byte  <= (inst.i.opcode == op_lb) || (inst.i.opcode == op_lbu);
            mem_op.zero_ext <= (inst.i.opcode == op_lbu);
        end
    end

    // r0 writes are dropped here
    assign rf_wen   = (alu_wen_q || (mem_done && load_q)) && (waddr_q != '0);
    assign rf_waddr = waddr_q;
    assign rf_wdata = mem_done ? load_data : wdata_q;

    // debug trace one cycle behind the write
    always_ff @(posedge clk) begin
        if (reset) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= rf_wen;
        end
    end

    always_ff @(posedge clk) begin
        trace.pc    <= pc_q;
        trace.wnum  <= rf_waddr;
        trace.wdata <= rf_wdata;
    end

endmodule

/* core/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk,
    input  logic                      reset,
    input  micro_core_pkg::reg_addr_t raddr1,
    input  micro_core_pkg::reg_addr_t raddr2,
    output micro_core_pkg::word_t     rdata1,
    output micro_core_pkg::word_t     rdata2,
    input  logic                      wen,
    input  micro_core_pkg::reg_addr_t waddr,
    input  micro_core_pkg::word_t     wdata
);
    import micro_core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read, r0 tied low
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* design/micro_core_top.sv */
`timescale 1ns/1ps

module micro_core_top #(
    parameter micro_core_pkg::word_t reset_pc = 32'h0
) (
    input  logic                     clk,
    input  logic                     reset,
    output logic                     mem_req,
    output micro_core_pkg::bus_req_t mem_cmd,
    input  logic                     mem_ack,
    input  micro_core_pkg::word_t    mem_rdata,
    output logic                     trace_valid,
    output micro_core_pkg::trace_t   trace
);
    import micro_core_pkg::*;

    // fetch to exec
    logic       inst_valid;
    logic       inst_take;
    inst_word_u inst;
    word_t      inst_pc;

    // register file
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    logic      rf_wen;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    // exec to load/store
    logic    mem_start;
    mem_op_t mem_op;
    logic    mem_done;
    word_t   load_data;

    // requesters to arbiter
    logic     fetch_req;
    logic     fetch_ack;
    bus_req_t fetch_cmd;
    logic     data_req;
    logic     data_ack;
    bus_req_t data_cmd;

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    fetch_unit #(
        .reset_pc(reset_pc)
    ) fetch_unit_i (
        .clk       (clk),
        .reset     (reset),
        .inst_take (inst_take),
        .inst_valid(inst_valid),
        .inst      (inst),
        .inst_pc   (inst_pc),
        .fetch_req (fetch_req),
        .fetch_cmd (fetch_cmd),
        .fetch_ack (fetch_ack),
        .rdata     (mem_rdata)
    );

    exec_unit exec_unit_i (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_take  (inst_take),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .rf_wen     (rf_wen),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .mem_start  (mem_start),
        .mem_op     (mem_op),
        .mem_done   (mem_done),
        .load_data  (load_data),
        .trace_valid(trace_valid),
        .trace      (trace)
    );

    reg_file reg_file_i (
        .clk   (clk),
        .reset (reset),
        .raddr1(rs_addr),
        .raddr2(rt_addr),
        .rdata1(rs_data),
        .rdata2(rt_data),
        .wen   (rf_wen),
        .waddr (rf_waddr),
        .wdata (rf_wdata)
    );

    load_store_unit load_store_unit_i (
        .clk      (clk),
        .reset    (reset),
        .mem_start(mem_start),
        .mem_op   (mem_op),
        .mem_done (mem_done),
        .load_data(load_data),
        .data_req (data_req),
        .data_cmd (data_cmd),
        .data_ack (data_ack),
        .rdata    (mem_rdata)
    );

    bus_arbiter bus_arbiter_i (
        .clk      (clk),
        .reset    (reset),
        .fetch_req(fetch_req),
        .fetch_cmd(fetch_cmd),
        .fetch_ack(fetch_ack),
        .data_req (data_req),
        .data_cmd (data_cmd),
        .data_ack (data_ack),
        .mem_req  (mem_req),
        .mem_cmd  (mem_cmd),
        .mem_ack  (mem_ack)
    );

endmodule

/* sim/micro_core_chk.sv */
`timescale 1ns/1ps

module micro_core_chk (
    input logic                     clk,
    input logic                     reset,
    input logic                     mem_req,
    input micro_core_pkg::bus_req_t mem_cmd,
    input logic                     mem_ack
);

    // set by any failing assertion
    logic fail_seen = 1'b0;

    // payload held while waiting for ack
    cmd_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> $stable(mem_cmd))
    else begin
        $error("mem_cmd changed while mem_req waited for ack");
        fail_seen = 1'b1;
    end

    req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req)
    else begin
        $error("mem_req dropped before ack");
        fail_seen = 1'b1;
    end

    // new request only after ack is low
    no_rise_on_ack: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !$past(mem_ack))
    else begin
        $error("mem_req rose while mem_ack was high");
        fail_seen = 1'b1;
    end

endmodule

bind micro_core_top micro_core_chk micro_core_chk_i (
    .clk    (clk),
    .reset  (reset),
    .mem_req(mem_req),
    .mem_cmd(mem_cmd),
    .mem_ack(mem_ack)
);

/* sim/micro_core_tb.sv */
`timescale 1ns/1ps

module micro_core_tb;
    import micro_core_pkg::*;

    localparam int n_prog        = 13;
    localparam int n_trace       = 10;
    localparam int trace_timeout = 100;
    localparam int idle_window   = 60;

    // memory model states
    localparam int st_idle  = 0;
    localparam int st_delay = 1;
    localparam int st_ack   = 2;

    logic     clk;
    logic     reset;
    logic     mem_req;
    bus_req_t mem_cmd;
    logic     mem_ack;
    word_t    mem_rdata;
    logic     trace_valid;
    trace_t   trace;

    word_t    mem [256];
    word_t    prog [n_prog];
    trace_t   expected [n_trace];
    int       seed;
    int       delay;
    int       mem_state;
    int       store_count;
    byte_en_t store_be;
    int       waited;
    int       entry;

    micro_core_top #(
        .reset_pc(32'h0)
    ) micro_core_top_i (
        .clk        (clk),
        .reset      (reset),
        .mem_req    (mem_req),
        .mem_cmd    (mem_cmd),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .trace_valid(trace_valid),
        .trace      (trace)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic word_t encode_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                       logic [5:0] funct);
        return {op_special, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t encode_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                       logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input word_t got, input word_t want, input string what);
        if (got !== want) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
            stop_run();
        end
    endtask

    task automatic load_tables();
        int j;
        // opcode 0x3f everywhere else, so stray fetches retire as no-ops
        for (j = 0; j < 256; j++) begin
            mem[j] = 32'hfc000000 | (word_t'(j) << 2);
        end
        prog[0]  = encode_i(op_lui, 5'd0, 5'd1, 16'h1234);
        prog[1]  = encode_i(op_ori, 5'd1, 5'd1, 16'h5678);
        prog[2]  = encode_i(op_addiu, 5'd0, 5'd2, 16'hfffc);
        prog[3]  = encode_r(5'd1, 5'd2, 5'd3, fn_addu);
        prog[4]  = encode_r(5'd1, 5'd2, 5'd4, fn_subu);
        prog[5]  = encode_r(5'd1, 5'd2, 5'd5, fn_or);
        prog[6]  = encode_i(op_sw, 5'd0, 5'd3, 16'h0100);
        prog[7]  = encode_i(op_lw, 5'd0, 5'd6, 16'h0100);
        prog[8]  = encode_i(op_lb, 5'd0, 5'd7, 16'h0105);
        prog[9]  = encode_i(op_lbu, 5'd0, 5'd8, 16'h0105);
        prog[10] = encode_i(op_addiu, 5'd0, 5'd0, 16'h0005);
        prog[11] = 32'h0;
        prog[12] = encode_i(op_addiu, 5'd0, 5'd9, 16'h0007);
        for (j = 0; j < n_prog; j++) begin
            mem[j] = prog[j];
        end
        mem[65] = 32'h000080f0;
        expected[0] = '{pc: 32'h00, wnum: 5'd1, wdata: 32'h12340000};
        expected[1] = '{pc: 32'h04, wnum: 5'd1, wdata: 32'h12345678};
        expected[2] = '{pc: 32'h08, wnum: 5'd2, wdata: 32'hfffffffc};
        expected[3] = '{pc: 32'h0c, wnum: 5'd3, wdata: 32'h12345674};
        expected[4] = '{pc: 32'h10, wnum: 5'd4, wdata: 32'h1234567c};
        expected[5] = '{pc: 32'h14, wnum: 5'd5, wdata: 32'hfffffffc};
        expected[6] = '{pc: 32'h1c, wnum: 5'd6, wdata: 32'h12345674};
        expected[7] = '{pc: 32'h20, wnum: 5'd7, wdata: 32'hffffff80};
        expected[8] = '{pc: 32'h24, wnum: 5'd8, wdata: 32'h00000080};
        expected[9] = '{pc: 32'h30, wnum: 5'd9, wdata: 32'h00000007};
    endtask

    task automatic access_memory();
        int idx;
        int b;
        idx = mem_cmd.addr[9:2];
        if (mem_cmd.write) begin
            for (b = 0; b < 4; b++) begin
                if (mem_cmd.be[b]) begin
                    mem[idx][b*8 +: 8] = mem_cmd.wdata[b*8 +: 8];
                end
            end
            store_be = mem_cmd.be;
            store_count++;
        end else begin
            mem_rdata = mem[idx];
        end
    endtask

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////

    // ack after 0 to 3 cycles, drop it once req is gone
    always @(negedge clk) begin
        if (reset) begin
            mem_ack   = 1'b0;
            mem_state = st_idle;
        end else if (mem_state == st_ack) begin
            if (!mem_req) begin
                mem_ack   = 1'b0;
                mem_state = st_idle;
            end
        end else begin
            if (mem_state == st_idle && mem_req) begin
                delay     = $random(seed) & 3;
                mem_state = st_delay;
            end
            if (mem_state == st_delay) begin
                if (delay == 0) begin
                    access_memory();
                    mem_ack   = 1'b1;
                    mem_state = st_ack;
                end else begin
                    delay--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (micro_core_top_i.micro_core_chk_i.fail_seen) begin
            $display("a bus protocol assertion failed");
            stop_run();
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        seed        = 32'hf834;
        reset       = 1'b1;
        mem_ack     = 1'b0;
        mem_rdata   = '0;
        mem_state   = st_idle;
        delay       = 0;
        store_count = 0;
        store_be    = '0;
        load_tables();
        repeat (3) @(negedge clk);
        reset = 1'b0;

        for (entry = 0; entry < n_trace; entry++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!trace_valid && waited < trace_timeout);
            if (!trace_valid) begin
                $display("timeout: trace entry %0d for pc %h never arrived",
                         entry, expected[entry].pc);
                stop_run();
            end
            check_value(trace.pc, expected[entry].pc, $sformatf("entry %0d pc", entry));
            check_value(word_t'(trace.wnum), word_t'(expected[entry].wnum),
                        $sformatf("entry %0d wnum", entry));
            check_value(trace.wdata, expected[entry].wdata,
                        $sformatf("entry %0d wdata", entry));
        end

        // stored word and its lanes
        check_value(mem[64], 32'h12345674, "memory word at 0x100");
        check_value(word_t'(store_be), 32'hf, "store byte enables");
        check_value(word_t'(store_count), 32'd1, "number of bus writes");

        // nothing more may show up on the trace
        repeat (idle_window) begin
            @(negedge clk);
            if (trace_valid) begin
                $display("unexpected trace entry for pc %h after the last one", trace.pc);
                stop_run();
            end
        end

        if (micro_core_top_i.micro_core_chk_i.fail_seen) begin
            $display("a bus protocol assertion failed");
            stop_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* micro_core.f */
common/micro_core_pkg.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/bus_arbiter.sv
core/exec_unit.sv
core/reg_file.sv
design/micro_core_top.sv
sim/micro_core_chk.sv
sim/micro_core_tb.sv

/* Bender.yml */
package:
  name: micro_core

sources:
  - common/micro_core_pkg.sv
  - design/fetch_unit.sv
  - design/load_store_unit.sv
  - design/bus_arbiter.sv
  - core/exec_unit.sv
  - core/reg_file.sv
  - design/micro_core_top.sv
  - target: test
    files:
      - sim/micro_core_chk.sv
      - sim/micro_core_tb.sv
